// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_dvs_hssl -f sources.f -o sim_tb

# tee keeps the pipeline status, the log search decides
./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== sources.f ====
+incdir+src
src/hssl_pkg.sv
src/pipe_reg.sv
src/route_table_regs.sv
src/pkt_assembler.sv
src/pkt_router.sv
src/dvs_hssl_top.sv
verif/tb_dvs_hssl.sv

// ==== src/dvs_hssl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hssl_cfg.svh"

module dvs_hssl_top
(
    input  wire                           pl_clk0_buf_int
  , input  wire                           rst

    // register bank access
  , input  hssl_pkg::apb_req_t            apb_req
  , output hssl_pkg::apb_rsp_t            apb_rsp

    // event source
  , input  wire [`HSSL_KEY_BITS-1:0]      evt_data
  , input  wire                           evt_vld
  , output logic                          evt_rdy

    // serial link packet channels
  , output hssl_pkg::mc_pkt_t             tx_pkt
  , output logic [`HSSL_NUM_CHANNELS-1:0] tx_vld
  , input  wire [`HSSL_NUM_CHANNELS-1:0]  tx_rdy
);

  import hssl_pkg::*;

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  route_table_t route_table;
  logic         link_stop;

  mc_pkt_t      asm_pkt;
  logic         asm_vld;
  logic         asm_rdy;

  // table and stop bit
  route_table_regs rb
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .apb_req         (apb_req)
    , .apb_rsp         (apb_rsp)
    , .route_table     (route_table)
    , .link_stop       (link_stop)
    );

  // events into packets
  pkt_assembler pa
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .link_stop       (link_stop)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .asm_pkt         (asm_pkt)
    , .asm_vld         (asm_vld)
    , .asm_rdy         (asm_rdy)
    );

  // packets onto channels
  pkt_router pr
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .route_table     (route_table)
    , .in_pkt          (asm_pkt)
    , .in_vld          (asm_vld)
    , .in_rdy          (asm_rdy)
    , .tx_pkt          (tx_pkt)
    , .tx_vld          (tx_vld)
    , .tx_rdy          (tx_rdy)
    );

endmodule

`default_nettype wire

// ==== src/hssl_cfg.svh ====
`ifndef HSSL_CFG_SVH
`define HSSL_CFG_SVH

// routing table and channel sizing
`define HSSL_NUM_ENTRIES   16
`define HSSL_NUM_CHANNELS  8
`define HSSL_ROUTE_BITS    3

// packet field widths
`define HSSL_KEY_BITS      32
`define HSSL_HDR_BITS      8

// APB address map, one word per table entry at a stride of 4
`define HSSL_APB_ADDR_BITS   12
`define HSSL_ADDR_STOP       12'h000
`define HSSL_ADDR_KEY_BASE   12'h100
`define HSSL_ADDR_MASK_BASE  12'h200
`define HSSL_ADDR_ROUTE_BASE 12'h300

`endif

// ==== src/hssl_pkg.sv ====
`default_nettype none

`include "hssl_cfg.svh"

package hssl_pkg;

  // multicast packet: header in the upper byte
  // hdr[0] makes the whole 40 bits odd parity
  typedef struct packed {
    logic [`HSSL_HDR_BITS-1:0] hdr;
    logic [`HSSL_KEY_BITS-1:0] key;
  } mc_pkt_t;

  // packet tagged with its output channel
  typedef struct packed {
    mc_pkt_t                     pkt;
    logic [`HSSL_ROUTE_BITS-1:0] route;
  } routed_pkt_t;

  // one routing table line
  typedef struct packed {
    logic [`HSSL_KEY_BITS-1:0]   key;
    logic [`HSSL_KEY_BITS-1:0]   mask;
    logic [`HSSL_ROUTE_BITS-1:0] route;
  } route_entry_t;

  typedef route_entry_t [`HSSL_NUM_ENTRIES-1:0] route_table_t;

  // APB request, master to slave
  typedef struct packed {
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`HSSL_APB_ADDR_BITS-1:0] paddr;
    logic [31:0]                   pwdata;
  } apb_req_t;

  // APB response, slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_reg
#(
  parameter type payload_t = logic
)
(
    input  wire      pl_clk0_buf_int
  , input  wire      rst

    // upstream side
  , input  payload_t in_data
  , input  wire      in_vld
  , output logic     in_rdy

    // downstream side
  , output payload_t out_data
  , output logic     out_vld
  , input  wire      out_rdy
);

  // free slot when empty or when the held item leaves this cycle
  assign in_rdy = !out_vld || out_rdy;

  // occupancy flag
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
      out_vld <= 1'b0;
    else if (in_rdy)
      out_vld <= in_vld;
  end

  // payload, loaded only on a transfer
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (in_rdy && in_vld)
      out_data <= in_data;
  end

  // ----------------------------------------------------------------------
  // stalled output keeps both valid and data
  // ----------------------------------------------------------------------
  hold_under_stall: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    out_vld && !out_rdy |=> out_vld && $stable(out_data)
  ) else $error("pipe_reg: output changed while stalled");

endmodule

`default_nettype wire

// ==== src/pkt_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hssl_cfg.svh"

module pkt_assembler
(
    input  wire                      pl_clk0_buf_int
  , input  wire                      rst
  , input  wire                      link_stop

    // incoming events
  , input  wire [`HSSL_KEY_BITS-1:0] evt_data
  , input  wire                      evt_vld
  , output logic                     evt_rdy

    // assembled packets
  , output hssl_pkg::mc_pkt_t        asm_pkt
  , output logic                     asm_vld
  , input  wire                      asm_rdy
);

  import hssl_pkg::*;

  mc_pkt_t new_pkt;
  logic    stage_rdy;

  // header is all zero except the parity bit
  // set it when the key has an even number of ones
  always_comb
  begin
    new_pkt.hdr    = '0;
    new_pkt.hdr[0] = ~^evt_data;
    new_pkt.key    = evt_data;
  end

  // link stop holds off the event source
  assign evt_rdy = stage_rdy && !link_stop;

  pipe_reg #(.payload_t(mc_pkt_t)) asm_stage
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .in_data         (new_pkt)
    , .in_vld          (evt_vld && !link_stop)
    , .in_rdy          (stage_rdy)
    , .out_data        (asm_pkt)
    , .out_vld         (asm_vld)
    , .out_rdy         (asm_rdy)
    );

  // no event taken while stopped
  no_accept_when_stopped: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    link_stop |-> !(evt_vld && evt_rdy)
  ) else $error("pkt_assembler: event accepted while link stopped");

endmodule

`default_nettype wire

// ==== src/pkt_router.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hssl_cfg.svh"

module pkt_router
(
    input  wire                         pl_clk0_buf_int
  , input  wire                         rst

    // routing table from register bank
  , input  hssl_pkg::route_table_t      route_table

    // incoming packet
  , input  hssl_pkg::mc_pkt_t           in_pkt
  , input  wire                         in_vld
  , output logic                        in_rdy

    // transmit channels, shared data
  , output hssl_pkg::mc_pkt_t           tx_pkt
  , output logic [`HSSL_NUM_CHANNELS-1:0] tx_vld
  , input  wire [`HSSL_NUM_CHANNELS-1:0]  tx_rdy
);

  import hssl_pkg::*;

  logic                        hit;
  logic [`HSSL_ROUTE_BITS-1:0] hit_route;
  routed_pkt_t                 lookup;
  routed_pkt_t                 held;
  logic                        held_vld;
  logic                        held_rdy;

  // ----------------------------------------------------------------------
  // table lookup, lowest matching index wins
  // ----------------------------------------------------------------------
  always_comb
  begin
    hit       = 1'b0;
    hit_route = '0;
    for (int i = 0; i < `HSSL_NUM_ENTRIES; i++)
    begin
      if (!hit && ((in_pkt.key & route_table[i].mask) == route_table[i].key))
      begin
        hit       = 1'b1;
        hit_route = route_table[i].route;
      end
    end
  end

  assign lookup.pkt   = in_pkt;
  assign lookup.route = hit_route;

  // a miss is consumed here and never enters the stage
  pipe_reg #(.payload_t(routed_pkt_t)) route_stage
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .in_data         (lookup)
    , .in_vld          (in_vld && hit)
    , .in_rdy          (in_rdy)
    , .out_data        (held)
    , .out_vld         (held_vld)
    , .out_rdy         (held_rdy)
    );

  // ----------------------------------------------------------------------
  // channel steering
  // ----------------------------------------------------------------------
  assign tx_pkt   = held.pkt;
  assign held_rdy = tx_rdy[held.route];

  always_comb
  begin
    for (int c = 0; c < `HSSL_NUM_CHANNELS; c++)
      tx_vld[c] = held_vld && (held.route == `HSSL_ROUTE_BITS'(c));
  end

  tx_vld_onehot: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    $onehot0(tx_vld)
  ) else $error("pkt_router: more than one tx_vld high");

endmodule

`default_nettype wire

// ==== src/route_table_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hssl_cfg.svh"

module route_table_regs
(
    input  wire                    pl_clk0_buf_int
  , input  wire                    rst

    // APB slave
  , input  hssl_pkg::apb_req_t     apb_req
  , output hssl_pkg::apb_rsp_t     apb_rsp

    // register contents
  , output hssl_pkg::route_table_t route_table
  , output logic                   link_stop
);

  import hssl_pkg::*;

  localparam int IDX_BITS = $clog2(`HSSL_NUM_ENTRIES);

  // address bits that pick the table entry
  localparam logic [`HSSL_APB_ADDR_BITS-1:0] IDX_FIELD =
    `HSSL_APB_ADDR_BITS'((`HSSL_NUM_ENTRIES - 1) << 2);

  logic                          access;
  logic [`HSSL_APB_ADDR_BITS-1:0] tbl_addr;
  logic [IDX_BITS-1:0]           idx;
  logic                          stop_sel;
  logic                          key_sel;
  logic                          mask_sel;
  logic                          route_sel;
  logic                          mapped;
  logic [31:0]                   rdata;

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  assign access   = apb_req.psel && apb_req.penable;
  assign tbl_addr = apb_req.paddr & ~IDX_FIELD;
  assign idx      = apb_req.paddr[IDX_BITS+1:2];

  // any stray bit outside index field lands unmapped
  assign stop_sel  = (apb_req.paddr == `HSSL_ADDR_STOP);
  assign key_sel   = (tbl_addr == `HSSL_ADDR_KEY_BASE);
  assign mask_sel  = (tbl_addr == `HSSL_ADDR_MASK_BASE);
  assign route_sel = (tbl_addr == `HSSL_ADDR_ROUTE_BASE);
  assign mapped    = stop_sel || key_sel || mask_sel || route_sel;

  // ----------------------------------------------------------------------
  // register writes, at the access edge
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
    begin
      route_table <= '0;
      link_stop   <= 1'b0;
    end
    else if (access && apb_req.pwrite)
    begin
      if (stop_sel)
        link_stop <= apb_req.pwdata[0];
      if (key_sel)
        route_table[idx].key <= apb_req.pwdata;
      if (mask_sel)
        route_table[idx].mask <= apb_req.pwdata;
      if (route_sel)
        route_table[idx].route <= apb_req.pwdata[`HSSL_ROUTE_BITS-1:0];
    end
  end

  // read mux, zero for unmapped
  always_comb
  begin
    rdata = '0;
    if (stop_sel)
      rdata[0] = link_stop;
    if (key_sel)
      rdata = route_table[idx].key;
    if (mask_sel)
      rdata = route_table[idx].mask;
    if (route_sel)
      rdata[`HSSL_ROUTE_BITS-1:0] = route_table[idx].route;
  end

  // zero wait states
  assign apb_rsp.prdata  = access ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !mapped;

  // ----------------------------------------------------------------------
  // master protocol checks
  // ----------------------------------------------------------------------
  penable_needs_psel: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    apb_req.penable |-> apb_req.psel
  ) else $error("route_table_regs: penable without psel");

  // setup phase always followed by its access phase
  setup_then_access: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable
  ) else $error("route_table_regs: setup not followed by access");

endmodule

`default_nettype wire

// ==== verif/tb_dvs_hssl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hssl_cfg.svh"

module tb_dvs_hssl;

  import hssl_pkg::*;

  localparam int          TIMEOUT = 2000;
  localparam logic [31:0] SEED    = 32'h4d92_a681;

  logic                            pl_clk0_buf_int = 1'b0;
  logic                            rst;
  apb_req_t                        apb_req;
  apb_rsp_t                        apb_rsp;
  logic [`HSSL_KEY_BITS-1:0]       evt_data;
  logic                            evt_vld;
  logic                            evt_rdy;
  mc_pkt_t                         tx_pkt;
  logic [`HSSL_NUM_CHANNELS-1:0]   tx_vld;
  logic [`HSSL_NUM_CHANNELS-1:0]   tx_rdy;

  // reference copy of the register bank
  logic [`HSSL_KEY_BITS-1:0]       ref_key   [`HSSL_NUM_ENTRIES];
  logic [`HSSL_KEY_BITS-1:0]       ref_mask  [`HSSL_NUM_ENTRIES];
  logic [`HSSL_ROUTE_BITS-1:0]     ref_route [`HSSL_NUM_ENTRIES];
  logic                            ref_stop;

  // expected packets with one queue per channel
  mc_pkt_t                         exp_q [`HSSL_NUM_CHANNELS][$];
  int                              pending;
  int                              accepted;
  int                              cycle;
  int                              accept_cycle;
  logic                            check_latency;
  logic                            rdy_random;
  logic [31:0]                     lcg_state;
  logic [31:0]                     exp_rdata;
  logic                            exp_slverr;

  always
  begin
    #50 pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  dvs_hssl_top dvs_hssl_top_i
    (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst             (rst)
    , .apb_req         (apb_req)
    , .apb_rsp         (apb_rsp)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .tx_pkt          (tx_pkt)
    , .tx_vld          (tx_vld)
    , .tx_rdy          (tx_rdy)
    );

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic logic [31:0] next_rand();
    // classic 32-bit LCG constants
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // odd parity over the 40-bit packet lives in hdr bit 0
  function automatic mc_pkt_t expect_pkt(input logic [`HSSL_KEY_BITS-1:0] key);
    mc_pkt_t p;
    p.key    = key;
    p.hdr    = '0;
    p.hdr[0] = ($countones(key) % 2 == 0);
    return p;
  endfunction

  // first entry with key & mask == entry key
  function automatic logic lookup_route(input logic [`HSSL_KEY_BITS-1:0] key,
                                        output logic [`HSSL_ROUTE_BITS-1:0] route);
    route = '0;
    for (int i = 0; i < `HSSL_NUM_ENTRIES; i++)
    begin
      if ((key & ref_mask[i]) == ref_key[i])
      begin
        route = ref_route[i];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // stop word or a word aligned inside one of the three tables
  function automatic logic addr_mapped(input logic [`HSSL_APB_ADDR_BITS-1:0] a);
    if (a == `HSSL_ADDR_STOP)
      return 1'b1;
    if (a[1:0] != 2'b00 || a[7:6] != 2'b00)
      return 1'b0;
    return (a[11:8] >= 4'h1) && (a[11:8] <= 4'h3);
  endfunction

  function automatic logic [31:0] model_read(input logic [`HSSL_APB_ADDR_BITS-1:0] a);
    logic [31:0] d;
    d = '0;
    case (a[11:8])
      4'h0:    d[0] = ref_stop;
      4'h1:    d = ref_key[a[5:2]];
      4'h2:    d = ref_mask[a[5:2]];
      default: d[`HSSL_ROUTE_BITS-1:0] = ref_route[a[5:2]];
    endcase
    return d;
  endfunction

  task automatic model_write(input logic [`HSSL_APB_ADDR_BITS-1:0] a, input logic [31:0] d);
    case (a[11:8])
      4'h0:    ref_stop = d[0];
      4'h1:    ref_key[a[5:2]] = d;
      4'h2:    ref_mask[a[5:2]] = d;
      default: ref_route[a[5:2]] = d[`HSSL_ROUTE_BITS-1:0];
    endcase
  endtask

  // every wait ends on a falling edge and redraws tx_rdy
  task automatic next_cycle();
    logic [31:0] bits;
    @(negedge pl_clk0_buf_int);
    bits   = rdy_random ? next_rand() : '1;
    tx_rdy = bits[23:16];
  endtask

  // setup cycle then access cycle
  task automatic apb_access(input logic wr, input logic [`HSSL_APB_ADDR_BITS-1:0] addr,
                            input logic [31:0] data);
    exp_slverr      = !addr_mapped(addr);
    exp_rdata       = exp_slverr ? 32'h0 : model_read(addr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    next_cycle();
    apb_req.penable = 1'b1;
    next_cycle();
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    // register took the write at the access edge
    if (wr && !exp_slverr)
      model_write(addr, data);
  endtask

  task automatic program_entry(input logic [3:0] idx, input logic [31:0] key,
                               input logic [31:0] mask, input logic [31:0] route);
    apb_access(1'b1, `HSSL_ADDR_KEY_BASE | {6'b0, idx, 2'b00}, key);
    apb_access(1'b1, `HSSL_ADDR_MASK_BASE | {6'b0, idx, 2'b00}, mask);
    apb_access(1'b1, `HSSL_ADDR_ROUTE_BASE | {6'b0, idx, 2'b00}, route);
  endtask

  task automatic send_event(input logic [`HSSL_KEY_BITS-1:0] key);
    int start;
    int n;
    start    = accepted;
    n        = 0;
    evt_data = key;
    evt_vld  = 1'b1;
    while (accepted == start)
    begin
      next_cycle();
      n++;
      if (n > TIMEOUT)
        abort_run("timeout waiting for the event to be accepted");
    end
    evt_vld = 1'b0;
  endtask

  // both stages empty and nothing left in the queues
  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 || tx_vld != '0 || dvs_hssl_top_i.asm_vld)
    begin
      next_cycle();
      n++;
      if (n > TIMEOUT)
        abort_run("timeout waiting for the packet channels to drain");
    end
  endtask

  // --------------------------------------------------------------------
  // scoreboard sampled on the rising edge
  // --------------------------------------------------------------------
  always @(posedge pl_clk0_buf_int)
  begin : scoreboard
    mc_pkt_t                     want;
    logic [`HSSL_ROUTE_BITS-1:0] route;
    cycle++;
    if (!rst)
    begin
      for (int c = 0; c < `HSSL_NUM_CHANNELS; c++)
      begin
        if (tx_vld[c] && tx_rdy[c])
        begin
          assert (exp_q[c].size() > 0)
            else abort_run($sformatf("unexpected packet 0x%h on channel %0d", tx_pkt, c));
          want = exp_q[c].pop_front();
          pending--;
          assert (tx_pkt == want)
            else abort_run($sformatf("mismatch tx_pkt: got 0x%h, expected 0x%h", tx_pkt, want));
          assert (!check_latency || cycle == accept_cycle + 2)
            else abort_run($sformatf("packet left %0d cycles after acceptance instead of 2",
                                     cycle - accept_cycle));
        end
      end
      // misses expect nothing
      if (evt_vld && evt_rdy)
      begin
        accepted++;
        accept_cycle = cycle;
        if (lookup_route(evt_data, route))
        begin
          exp_q[route].push_back(expect_pkt(evt_data));
          pending++;
        end
      end
    end
  end

  // protocol checks
  apb_error_flag: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    apb_req.psel && apb_req.penable |-> apb_rsp.pslverr == exp_slverr
  ) else abort_run($sformatf("mismatch pslverr: got 0x%h, expected 0x%h",
                             apb_rsp.pslverr, exp_slverr));

  apb_read_data: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    apb_req.psel && apb_req.penable && !apb_req.pwrite |-> apb_rsp.prdata == exp_rdata
  ) else abort_run($sformatf("mismatch prdata: got 0x%h, expected 0x%h",
                             apb_rsp.prdata, exp_rdata));

  apb_ready: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    apb_req.psel && apb_req.penable |-> apb_rsp.pready
  ) else abort_run("pready was low in an access cycle");

  // stalled channel keeps packet and valid
  tx_hold: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    (tx_vld != '0) && ((tx_vld & tx_rdy) == '0) |=> $stable(tx_pkt) && $stable(tx_vld)
  ) else abort_run($sformatf("mismatch tx_pkt under stall: now 0x%h with tx_vld 0x%h",
                             tx_pkt, tx_vld));

  tx_parity: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    (tx_vld != '0) |-> ^tx_pkt
  ) else abort_run($sformatf("mismatch tx_pkt parity: 0x%h is even", tx_pkt));

  tx_one_channel: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    $onehot0(tx_vld)
  ) else abort_run($sformatf("mismatch tx_vld: 0x%h is not one-hot", tx_vld));

  stop_blocks_events: assert property (
    @(posedge pl_clk0_buf_int) disable iff (rst)
    ref_stop |-> !evt_rdy
  ) else abort_run($sformatf("mismatch evt_rdy while stopped: got 0x%h, expected 0x0", evt_rdy));

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------
  initial
  begin : stimulus
    logic [31:0] r;
    logic [31:0] key;
    int          start;
    rst           = 1'b1;
    apb_req       = '0;
    evt_data      = '0;
    evt_vld       = 1'b0;
    tx_rdy        = '1;
    pending       = 0;
    accepted      = 0;
    cycle         = 0;
    accept_cycle  = 0;
    check_latency = 1'b0;
    rdy_random    = 1'b0;
    lcg_state     = SEED;
    exp_rdata     = '0;
    exp_slverr    = 1'b0;
    ref_stop      = 1'b0;
    for (int i = 0; i < `HSSL_NUM_ENTRIES; i++)
    begin
      ref_key[i]   = '0;
      ref_mask[i]  = '0;
      ref_route[i] = '0;
    end
    next_cycle();
    next_cycle();
    rst = 1'b0;

    // reset state
    assert (evt_rdy === 1'b1)
      else abort_run($sformatf("mismatch evt_rdy after reset: got 0x%h, expected 0x1", evt_rdy));
    assert (tx_vld === '0)
      else abort_run($sformatf("mismatch tx_vld after reset: got 0x%h, expected 0x0", tx_vld));
    assert (dvs_hssl_top_i.asm_vld === 1'b0)
      else abort_run("asm_vld was high after reset");
    assert (apb_rsp.pslverr === 1'b0)
      else abort_run("pslverr was high after reset");

    // register write and read back and then bad addresses
    apb_access(1'b1, 12'h114, 32'hdead_beef);
    apb_access(1'b1, 12'h214, 32'h0f0f_1234);
    apb_access(1'b1, 12'h314, 32'hffff_fffd);
    apb_access(1'b0, 12'h114, '0);
    apb_access(1'b0, 12'h214, '0);
    apb_access(1'b0, 12'h314, '0);
    apb_access(1'b0, 12'h004, '0);
    apb_access(1'b0, 12'h102, '0);
    apb_access(1'b1, 12'h400, 32'h1234_5678);
    apb_access(1'b0, `HSSL_ADDR_STOP, '0);

    // untouched entry 0 catches everything
    repeat (8)
      send_event(next_rand());
    wait_drain();

    // idle entries can never match
    for (int i = 0; i < `HSSL_NUM_ENTRIES; i++)
      program_entry(4'(i), 32'hffff_ffff, 32'h0, 32'h0);
    program_entry(4'd0, 32'haa00_0000, 32'hff00_0000, 32'd2);
    program_entry(4'd1, 32'ha000_0000, 32'hf000_0000, 32'd5);
    program_entry(4'd2, 32'h0000_0003, 32'h0000_000f, 32'd7);
    send_event(32'haa12_3456);
    send_event(32'ha512_3450);
    send_event(32'h1234_5673);
    send_event(32'hab00_0003);
    send_event(32'haa00_0003);
    wait_drain();

    // misses and then resumed flow
    send_event(32'h1234_5670);
    send_event(32'h5555_0000);
    send_event(32'ha000_0001);
    wait_drain();

    // lone event with all channels ready
    check_latency = 1'b1;
    send_event(32'haa00_0042);
    wait_drain();
    check_latency = 1'b0;

    // random back-pressure across channels 2, 5, 7 and misses
    rdy_random = 1'b1;
    repeat (60)
    begin
      r = next_rand();
      case (r[31:30])
        2'd0:    key = {8'haa, r[23:0]};
        2'd1:    key = {4'ha, r[27:0]};
        2'd2:    key = {r[27:0], 4'h3};
        default: key = r;
      endcase
      send_event(key);
    end
    wait_drain();
    rdy_random = 1'b0;

    // link stop holds the source off
    apb_access(1'b1, `HSSL_ADDR_STOP, 32'h1);
    apb_access(1'b0, `HSSL_ADDR_STOP, '0);
    start    = accepted;
    r        = next_rand();
    key      = {8'haa, r[23:0]};
    evt_data = key;
    evt_vld  = 1'b1;
    repeat (10)
      next_cycle();
    assert (accepted == start)
      else abort_run("an event was accepted while the link was stopped");
    apb_access(1'b1, `HSSL_ADDR_STOP, 32'h0);
    send_event(key);
    wait_drain();

    if (pending == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
      abort_run("expected packets never left the DUT");
  end

endmodule

`default_nettype wire
